// File: rtl/scope_pkg.sv
package scope_pkg;

    localparam int bit_cycles      = 16;  // clocks per serial bit.
    localparam int capture_depth   = 32;
    localparam int burst_cycles    = 64;
    localparam int pwm_period_bits = 9;

    localparam int bit_cnt_bits   = $clog2(bit_cycles);
    localparam int burst_cnt_bits = $clog2(burst_cycles);

    typedef logic [7:0]                byte_t;
    typedef logic [4:0]                addr_t;
    typedef logic [bit_cnt_bits-1:0]   bit_cnt_t;
    typedef logic [burst_cnt_bits-1:0] burst_cnt_t;

    // command characters, ascii.
    typedef enum logic [7:0] {
        cmd_capture = 8'h63,
        cmd_dump    = 8'h64,
        cmd_burst   = 8'h62
    } cmd_t;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;
    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;

    typedef enum logic [2:0] {
        dump_idle, dump_fetch, dump_hi, dump_lo, dump_cr, dump_lf
    } dump_state_t;

    typedef struct packed {
        logic  done;
        addr_t wr_addr;
    } cap_status_t;

endpackage

// File: rtl/acia_rx.sv
`timescale 1ns/1ps

module acia_rx import scope_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx_serial,
    output byte_t rx_dat,
    output logic  rx_stb,
    output logic  rx_err
);

    logic      rx_meta;
    logic      rx_s;
    rx_state_t state;
    bit_cnt_t  cnt;
    logic [2:0] bit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;  // line idles high.
            rx_s    <= 1'b1;
            state   <= rx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            rx_stb  <= 1'b0;
            rx_err  <= 1'b0;
        end else begin
            rx_meta <= rx_serial;
            rx_s    <= rx_meta;
            rx_stb  <= 1'b0;
            rx_err  <= 1'b0;
            if (state != rx_idle)
                cnt <= cnt - 1'b1;
            case (state)
                rx_idle: if (!rx_s) begin
                    state <= rx_start;
                    cnt   <= bit_cnt_t'(bit_cycles / 2 - 1);  // aim at mid start bit.
                end
                rx_start: if (cnt == '0) begin
                    if (rx_s) begin
                        state <= rx_idle;  // glitch, not a start bit.
                    end else begin
                        state   <= rx_data;
                        cnt     <= bit_cnt_t'(bit_cycles - 1);
                        bit_idx <= '0;
                    end
                end
                rx_data: if (cnt == '0) begin
                    cnt     <= bit_cnt_t'(bit_cycles - 1);
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= rx_stop;
                end
                default: if (cnt == '0) begin
                    state  <= rx_idle;
                    rx_stb <= 1'b1;
                    rx_err <= !rx_s;  // stop bit must be high.
                end
            endcase
        end
    end

    // lsb first.
    always_ff @(posedge clk) begin
        if (state == rx_data && cnt == '0)
            rx_dat <= {rx_s, rx_dat[7:1]};
    end

endmodule

// File: rtl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode import scope_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t rx_dat,
    input  logic  rx_stb,
    input  logic  rx_err,
    output logic  start_capture,
    output logic  start_dump,
    output logic  start_burst
);

    cmd_t cmd;
    logic good;

    assign cmd  = cmd_t'(rx_dat);
    assign good = rx_stb && !rx_err;  // framing errors dropped.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_capture <= 1'b0;
            start_dump    <= 1'b0;
            start_burst   <= 1'b0;
        end else begin
            start_capture <= 1'b0;
            start_dump    <= 1'b0;
            start_burst   <= 1'b0;
            if (good) begin
                case (cmd)
                    cmd_capture: start_capture <= 1'b1;
                    cmd_dump:    start_dump    <= 1'b1;
                    cmd_burst:   start_burst   <= 1'b1;
                    default: ;  // unknown byte.
                endcase
            end
        end
    end

endmodule

// File: rtl/capture_buf.sv
`timescale 1ns/1ps

module capture_buf import scope_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        lvds_in,
    input  logic        start_capture,
    input  addr_t       rd_addr,
    output logic        comp_in,
    output cap_status_t status,
    output byte_t       rd_dat
);

    logic       in_meta;
    logic       sig;
    logic       active;
    logic       last_store;
    logic       cap_done;
    logic [2:0] bit_cnt;
    logic       store;
    addr_t      wr_addr;
    byte_t      shreg;
    byte_t      mem [capture_depth];

    // eighth sample of a byte goes straight into the ram.
    assign store = active && !start_capture && bit_cnt == 3'd7;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta    <= 1'b0;
            sig        <= 1'b0;
            comp_in    <= 1'b0;
            active     <= 1'b0;
            last_store <= 1'b0;
            cap_done   <= 1'b0;
            bit_cnt    <= '0;
            wr_addr    <= '0;
        end else begin
            in_meta    <= lvds_in;
            sig        <= in_meta;
            comp_in    <= sig;  // feedback to the comparator.
            last_store <= 1'b0;
            if (start_capture) begin
                active   <= 1'b1;
                bit_cnt  <= 3'd1;  // first sample taken now.
                wr_addr  <= '0;
                cap_done <= 1'b0;
            end else if (active) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (store) begin
                    wr_addr <= wr_addr + 1'b1;
                    if (wr_addr == addr_t'(capture_depth - 1)) begin
                        active     <= 1'b0;
                        last_store <= 1'b1;
                    end
                end
            end else if (last_store) begin
                cap_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_capture || active)
            shreg <= {shreg[6:0], sig};  // msb first.
        if (store)
            mem[wr_addr] <= {shreg[6:0], sig};
    end

    assign rd_dat = mem[rd_addr];
    assign status = '{done: cap_done, wr_addr: wr_addr};

endmodule

// File: rtl/burst_gen.sv
`timescale 1ns/1ps

module burst_gen import scope_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start_burst,
    output logic tx_out,
    output logic pwm_out
);

    burst_cnt_t                 cnt;
    logic [pwm_period_bits-1:0] pwm_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            tx_out  <= 1'b0;
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (start_burst) begin
                cnt    <= burst_cnt_t'(burst_cycles - 1);
                tx_out <= 1'b1;  // odd toggles left, so it ends low.
            end else if (cnt != '0) begin
                cnt    <= cnt - 1'b1;
                tx_out <= !tx_out;
            end else begin
                tx_out <= 1'b0;
            end
        end
    end

    assign pwm_out = pwm_cnt[pwm_period_bits-1];  // half duty.

endmodule

// File: rtl/acia_tx.sv
`timescale 1ns/1ps

module acia_tx import scope_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tx_stb,
    input  byte_t tx_dat,
    output logic  tx_serial,
    output logic  tx_busy
);

    tx_state_t  state;
    bit_cnt_t   cnt;
    logic [2:0] bit_idx;
    byte_t      shreg;

    assign tx_busy = (state != tx_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= tx_idle;
            cnt       <= '0;
            bit_idx   <= '0;
            tx_serial <= 1'b1;
        end else begin
            if (state != tx_idle)
                cnt <= cnt - 1'b1;
            case (state)
                tx_idle: if (tx_stb) begin
                    state     <= tx_start;
                    cnt       <= bit_cnt_t'(bit_cycles - 1);
                    tx_serial <= 1'b0;
                end
                tx_start: if (cnt == '0) begin
                    state     <= tx_data;
                    cnt       <= bit_cnt_t'(bit_cycles - 1);
                    bit_idx   <= '0;
                    tx_serial <= shreg[0];
                end
                tx_data: if (cnt == '0) begin
                    cnt <= bit_cnt_t'(bit_cycles - 1);
                    if (bit_idx == 3'd7) begin
                        state     <= tx_stop;
                        tx_serial <= 1'b1;
                    end else begin
                        bit_idx   <= bit_idx + 1'b1;
                        tx_serial <= shreg[0];
                    end
                end
                default: if (cnt == '0)
                    state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == tx_idle && tx_stb)
            shreg <= tx_dat;
        else if (cnt == '0 && (state == tx_start || state == tx_data))
            shreg <= shreg >> 1;  // next bit to bit 0.
    end

endmodule

// File: rtl/hex_dump.sv
`timescale 1ns/1ps

module hex_dump import scope_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_dump,
    input  cap_status_t status,
    input  byte_t       rd_dat,
    output addr_t       rd_addr,
    output logic        fpga_tx,
    output logic        dump_busy
);

    dump_state_t state;
    byte_t       cur;
    byte_t       tx_dat;
    logic        tx_stb;
    logic        tx_busy;
    logic        send;

    function automatic byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10)
            return 8'h30 + byte_t'(nib);
        return 8'h37 + byte_t'(nib);  // 'A' for 10.
    endfunction

    // tx_busy lags the strobe by a cycle, hence the tx_stb term.
    assign send = !tx_busy && !tx_stb &&
                  (state == dump_hi || state == dump_lo ||
                   state == dump_cr || state == dump_lf);
    assign dump_busy = (state != dump_idle) || tx_stb || tx_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= dump_idle;
            rd_addr <= '0;
            tx_stb  <= 1'b0;
        end else begin
            tx_stb <= send;
            case (state)
                dump_idle: if (start_dump && status.done && !dump_busy) begin
                    state   <= dump_fetch;
                    rd_addr <= '0;
                end
                dump_fetch: state <= dump_hi;
                dump_hi: if (send)
                    state <= dump_lo;
                dump_lo: if (send) begin
                    if (rd_addr == addr_t'(capture_depth - 1)) begin
                        state <= dump_cr;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                        state   <= dump_fetch;
                    end
                end
                dump_cr: if (send)
                    state <= dump_lf;
                dump_lf: if (send)
                    state <= dump_idle;  // busy holds until lf is out.
                default: state <= dump_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dump_fetch)
            cur <= rd_dat;
        if (send) begin
            case (state)
                dump_hi: tx_dat <= hex_char(cur[7:4]);
                dump_lo: tx_dat <= hex_char(cur[3:0]);
                dump_cr: tx_dat <= 8'h0d;
                default: tx_dat <= 8'h0a;
            endcase
        end
    end

    acia_tx acia_tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_stb   (tx_stb),
        .tx_dat   (tx_dat),
        .tx_serial(fpga_tx),
        .tx_busy  (tx_busy)
    );

endmodule

// File: rtl/scope_top.sv
`timescale 1ns/1ps

module scope_top import scope_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic fpga_rx,
    input  logic lvds_in,
    output logic fpga_tx,
    output logic comp_in,
    output logic tx_out,
    output logic pwm_out,
    output logic led1,
    output logic led2
);

    byte_t       rx_dat;
    logic        rx_stb;
    logic        rx_err;
    logic        start_capture;
    logic        start_dump;
    logic        start_burst;
    cap_status_t cap_status;
    addr_t       rd_addr;
    byte_t       rd_dat;

    acia_rx acia_rx_i (
        .clk(clk), .rst_n(rst_n), .rx_serial(fpga_rx),
        .rx_dat(rx_dat), .rx_stb(rx_stb), .rx_err(rx_err)
    );

    cmd_decode cmd_decode_i (
        .clk(clk), .rst_n(rst_n), .rx_dat(rx_dat), .rx_stb(rx_stb), .rx_err(rx_err),
        .start_capture(start_capture), .start_dump(start_dump), .start_burst(start_burst)
    );

    capture_buf capture_buf_i (
        .clk(clk), .rst_n(rst_n), .lvds_in(lvds_in), .start_capture(start_capture),
        .rd_addr(rd_addr), .comp_in(comp_in), .status(cap_status), .rd_dat(rd_dat)
    );

    burst_gen burst_gen_i (
        .clk(clk), .rst_n(rst_n), .start_burst(start_burst),
        .tx_out(tx_out), .pwm_out(pwm_out)
    );

    hex_dump hex_dump_i (
        .clk(clk), .rst_n(rst_n), .start_dump(start_dump), .status(cap_status),
        .rd_dat(rd_dat), .rd_addr(rd_addr), .fpga_tx(fpga_tx), .dump_busy(led1)
    );

    assign led2 = cap_status.done;  // capture done.

endmodule

// File: sim/tb_scope.sv
`timescale 1ns/1ps

module tb_scope import scope_pkg::*; ();

    localparam int rx_lat     = 2 + bit_cycles * 19 / 2;  // start edge to rx_stb.
    localparam int max_cycles = 20000;  // about 1.5x the full run.

    logic   clk;
    logic   rst_n;
    logic   fpga_rx;
    logic   lvds_in;
    logic   fpga_tx, comp_in, tx_out, pwm_out, led1, led2;
    int     cyc = 0;
    int     checks = 0;
    int     errors = 0;
    logic [31:0] lfsr;
    logic   hist [max_cycles + 2];  // lvds_in as seen by each posedge.
    byte_t  rx_chars [$];

    scope_top scope_top_i (
        .clk(clk), .rst_n(rst_n), .fpga_rx(fpga_rx), .lvds_in(lvds_in),
        .fpga_tx(fpga_tx), .comp_in(comp_in), .tx_out(tx_out), .pwm_out(pwm_out),
        .led1(led1), .led2(led2)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1.
    endfunction

    function automatic byte_t ascii_hex(input logic [3:0] n);
        if (n < 4'd10)
            return 8'h30 + 8'(n);
        return 8'h41 + 8'(n) - 8'd10;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // start bit, 8 data bits lsb first, stop bit.
    task automatic send_byte(input byte_t b, input logic stop, output int start_cyc);
        int i;
        @(negedge clk);
        fpga_rx = 1'b0;
        start_cyc = cyc;
        repeat (bit_cycles) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            fpga_rx = b[i];
            repeat (bit_cycles) @(negedge clk);
        end
        fpga_rx = stop;
        repeat (bit_cycles) @(negedge clk);
        fpga_rx = 1'b1;
    endtask

    task automatic check_burst();
        int s;
        int pulse;
        int m;
        int high;
        @(negedge clk);
        s = cyc;
        pulse = s + rx_lat + 2;
        while (cyc < pulse) @(negedge clk);
        check_eq("tx_out before burst", 0, tx_out);
        @(negedge clk);
        for (m = 0; m < burst_cycles + 16; m++) begin
            check_eq("tx_out burst", (m < burst_cycles) && (m % 2 == 0), tx_out);
            @(negedge clk);
        end
        high = 0;
        repeat (512) begin
            high += pwm_out;
            @(negedge clk);
        end
        check_eq("pwm_out high count", 256, high);
    endtask

    // lfsr bits on lvds_in, one per clock.
    always @(negedge clk) begin
        lfsr = lfsr_next(lfsr);
        lvds_in = lfsr[0];
        hist[cyc + 1] = lfsr[0];
    end

    always @(negedge clk) begin
        if (rst_n && cyc >= 6)
            check_eq("comp_in delay", hist[cyc - 2], comp_in);
    end

    // dump busy only with a finished capture.
    assert property (@(negedge clk) disable iff (!rst_n) led1 |-> led2)
        else begin
            errors++;
            $display("dump busy LED came on without a finished capture");
        end

    initial begin : serial_monitor
        byte_t c;
        int i;
        forever begin
            @(negedge clk);
            if (rst_n && fpga_tx === 1'b0) begin
                repeat (bit_cycles / 2) @(negedge clk);
                check_eq("tx start bit", 0, fpga_tx);
                for (i = 0; i < 8; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    c[i] = fpga_tx;
                end
                repeat (bit_cycles) @(negedge clk);
                check_eq("tx stop bit", 1, fpga_tx);
                rx_chars.push_back(c);
            end
        end
    end

    initial begin
        int s, pulse, b, t, i;
        byte_t model [capture_depth];
        clk = 1'b0;
        rst_n = 1'b0;
        fpga_rx = 1'b1;
        lvds_in = 1'b0;
        lfsr = 32'h8d52;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("reset fpga_tx", 1, fpga_tx);
        check_eq("reset led1", 0, led1);
        check_eq("reset led2", 0, led2);
        check_eq("reset tx_out", 0, tx_out);
        check_eq("reset pwm_out", 0, pwm_out);

        // dump without capture, unknown byte, framing error.
        send_byte(cmd_dump, 1'b1, s);
        repeat (2 * bit_cycles) @(negedge clk);
        send_byte(8'h5a, 1'b1, s);
        repeat (2 * bit_cycles) @(negedge clk);
        send_byte(cmd_capture, 1'b0, s);
        // long enough for a wrongly started capture to finish.
        repeat (8 * capture_depth + 4 * bit_cycles) @(negedge clk);
        check_eq("no output before capture", 0, rx_chars.size());
        check_eq("led2 after bad commands", 0, led2);

        send_byte(cmd_capture, 1'b1, s);
        while (led2 !== 1'b1) @(negedge clk);
        pulse = s + rx_lat + 2;
        check_eq("led2 rise cycle", pulse + 8 * capture_depth + 1, cyc);
        for (b = 0; b < capture_depth; b++)
            for (t = 0; t < 8; t++)
                model[b][7 - t] = hist[pulse - 1 + 8 * b + t];  // msb first.

        send_byte(cmd_dump, 1'b1, s);
        check_eq("led1 dump start", 1, led1);
        while (rx_chars.size() < 2 * capture_depth + 2) begin
            check_eq("led1 during dump", 1, led1);
            @(negedge clk);
        end
        repeat (bit_cycles) @(negedge clk);
        check_eq("led1 after dump", 0, led1);
        check_eq("dump length", 2 * capture_depth + 2, rx_chars.size());
        for (i = 0; i < capture_depth; i++) begin
            check_eq("dump high nibble", ascii_hex(model[i][7:4]), rx_chars[2 * i]);
            check_eq("dump low nibble", ascii_hex(model[i][3:0]), rx_chars[2 * i + 1]);
        end
        check_eq("dump cr", 8'h0d, rx_chars[2 * capture_depth]);
        check_eq("dump lf", 8'h0a, rx_chars[2 * capture_depth + 1]);

        fork
            send_byte(cmd_burst, 1'b1, s);
            check_burst();
        join

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: sim.f
rtl/scope_pkg.sv
rtl/acia_rx.sv
rtl/cmd_decode.sv
rtl/capture_buf.sv
rtl/burst_gen.sv
rtl/acia_tx.sv
rtl/hex_dump.sv
rtl/scope_top.sv
sim/tb_scope.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scope testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_scope -f sim.f -o tb_scope
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_scope > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
